/* logic/fpu_pkg.sv */
package fpu_pkg;

	typedef logic [23:0] man_t;	// hidden bit included.
	typedef logic [9:0] exp_t;	// unbiased, two's complement.
	typedef logic [31:0] word_t;
	typedef logic [4:0] flags_t;

	typedef enum logic [2:0] {
		RNE = 3'd0,
		RTZ = 3'd1,
		RDN = 3'd2,
		RUP = 3'd3,
		RMM = 3'd4,
		DYN = 3'd7
	} rm_t;

	localparam int exp_bias = 127;

	// bit positions in flags_t.
	localparam int flag_nv = 4;
	localparam int flag_dz = 3;
	localparam int flag_of = 2;
	localparam int flag_uf = 1;
	localparam int flag_nx = 0;

	localparam logic [31:0] csr_frm_addr = 32'h0;
	localparam logic [31:0] csr_fflags_addr = 32'h4;

endpackage

/* logic/float_unpack.sv */
`timescale 1ns/1ns

module float_unpack (
	input	fpu_pkg::word_t	a,
	input	fpu_pkg::word_t	b,
	input	fpu_pkg::rm_t	rm,
	input	fpu_pkg::rm_t	frm,
	output	fpu_pkg::man_t	man_a,
	output	fpu_pkg::man_t	man_b,
	output	fpu_pkg::exp_t	exp_a,
	output	fpu_pkg::exp_t	exp_b,
	output	logic		sgn_a,
	output	logic		sgn_b,
	output	logic		zero_a,
	output	logic		zero_b,
	output	logic		inf_a,
	output	logic		inf_b,
	output	logic		snan_a,
	output	logic		snan_b,
	output	logic		qnan_a,
	output	logic		qnan_b,
	output	fpu_pkg::rm_t	rm_sel
);
	import fpu_pkg::*;

	// {man, exp, sgn, zero, inf, snan, qnan}.
	function automatic logic [38:0] split(input word_t w);
		logic [7:0] e;
		logic [22:0] f;
		logic nan;
		e = w[30:23];
		f = w[22:0];
		nan = (e == 8'hff) && (f != 23'd0);
		// subnormals land in the zero class.
		return {e != 8'h00, f, exp_t'({2'b00, e}) - exp_t'(exp_bias), w[31],
			e == 8'h00, (e == 8'hff) && (f == 23'd0), nan && !f[22], nan && f[22]};
	endfunction

	assign {man_a, exp_a, sgn_a, zero_a, inf_a, snan_a, qnan_a} = split(a);
	assign {man_b, exp_b, sgn_b, zero_b, inf_b, snan_b, qnan_b} = split(b);

	assign rm_sel = (rm == DYN) ? frm : rm;	// dynamic mode from csr.

endmodule

/* logic/float_divider.sv */
`timescale 1ns/1ns

module float_divider #(
	parameter int div_steps = 13
) (
	input	logic		clk,
	input	logic		reset,
	input	logic		valid_in,
	output	logic		ready_out,
	output	logic		valid_out,
	input	logic		ready_in,
	input	fpu_pkg::rm_t	rm,
	input	fpu_pkg::man_t	man_a,
	input	fpu_pkg::exp_t	exp_a,
	input	logic		sgn_a,
	input	logic		zero_a,
	input	logic		inf_a,
	input	logic		snan_a,
	input	logic		qnan_a,
	input	fpu_pkg::man_t	man_b,
	input	fpu_pkg::exp_t	exp_b,
	input	logic		sgn_b,
	input	logic		zero_b,
	input	logic		inf_b,
	input	logic		snan_b,
	input	logic		qnan_b,
	output	fpu_pkg::man_t	man_y,
	output	fpu_pkg::exp_t	exp_y,
	output	logic		sgn_y,
	output	logic		round_bit,
	output	logic		sticky_bit,
	output	logic		skip_round,
	output	logic		iv,
	output	logic		dz,
	output	fpu_pkg::rm_t	rm_out
);
	import fpu_pkg::*;

	localparam int q_w = 2 * div_steps;
	localparam int cnt_w = $clog2(div_steps + 1);

	typedef enum logic {IDLE, CALC} state_t;

	state_t			state;
	logic [cnt_w-1:0]	counter;
	man_t			reg_man_b;
	logic [q_w-1:0]		reg_res;
	logic [26:0]		reg_rem;
	exp_t			reg_exp_y;
	logic			reg_sgn_y;

	logic			accept;
	logic			step;
	logic			iv_int;
	logic			dz_int;
	logic			nan_y;
	logic			inf_y;
	logic			zero_y;
	logic			special;
	logic			no_shift;
	logic [q_w-1:0]		norm;
	logic [26:0]		trial;
	logic [26:0]		acc [3];
	logic [1:0]		q;

	assign iv_int = snan_a || snan_b || (zero_a && zero_b) || (inf_a && inf_b);
	assign nan_y = iv_int || qnan_a || qnan_b;
	assign inf_y = inf_a || zero_b;
	assign zero_y = zero_a || inf_b;
	assign special = nan_y || inf_y || zero_y;
	assign dz_int = zero_b && !zero_a && !inf_a && !nan_y;	// finite nonzero over zero.

	// refuse input while a result waits for round/pack.
	assign ready_out = ready_in && (state == IDLE);
	assign accept = valid_in && ready_out;
	assign step = (state == CALC) && (counter != cnt_w'(div_steps));

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= IDLE;
			valid_out <= 1'b0;
			counter <= '0;
		end else if (accept) begin
			counter <= '0;
			valid_out <= special;
			state <= special ? IDLE : CALC;
		end else if (state == CALC) begin
			if (counter == cnt_w'(div_steps)) begin
				valid_out <= 1'b1;
				state <= IDLE;
			end else
				counter <= counter + 1'b1;
		end else if (valid_out && ready_in)
			valid_out <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			reg_man_b <= man_b;
			reg_res <= '0;
			reg_rem <= {1'b0, man_a, 2'b00};
			reg_exp_y <= exp_a - exp_b;
			reg_sgn_y <= sgn_a ^ sgn_b;
			skip_round <= special;
			iv <= iv_int;
			dz <= dz_int;
			rm_out <= rm;
			if (nan_y) begin	// canonical quiet nan.
				reg_res <= {24'hc00000, {(q_w-24){1'b0}}};
				reg_rem <= '0;
				reg_exp_y <= 10'h0ff;
				reg_sgn_y <= 1'b0;
			end else if (inf_y) begin
				reg_res <= {24'h800000, {(q_w-24){1'b0}}};
				reg_rem <= '0;
				reg_exp_y <= 10'h0ff;
			end else if (zero_y) begin
				reg_rem <= '0;
				reg_exp_y <= 10'h000;
			end
		end else if (step) begin
			reg_res <= {reg_res[q_w-3:0], q};
			reg_rem <= acc[2];
		end
	end

	// two restoring steps per cycle.
	always_comb begin
		acc[0] = reg_rem;
		q = 2'b00;
		trial = '0;
		for (int i = 1; i <= 2; i++) begin
			trial = acc[i-1] - {1'b0, reg_man_b, 2'b00};
			q[2-i] = !trial[26];
			acc[i] = (trial[26] ? acc[i-1] : trial) << 1;
		end
	end

	assign no_shift = reg_res[q_w-1] || skip_round;
	assign norm = no_shift ? reg_res : reg_res << 1;

	always_comb begin
		sgn_y = reg_sgn_y;
		exp_y = no_shift ? reg_exp_y : reg_exp_y - 10'd1;
		man_y = norm[q_w-1 -: 24];
		round_bit = norm[q_w-25];
		sticky_bit = |norm[q_w-26:0] || |reg_rem;	// extra guard bits fold in here.
	end

	hold_result: assert property (@(posedge clk) disable iff (reset)
		valid_out && !ready_in |=> valid_out);

	quotient_normal: assert property (@(posedge clk) disable iff (reset)
		state == CALC && counter == cnt_w'(div_steps) |-> reg_res[q_w-1 -: 2] != 2'b00);

endmodule

/* logic/float_round_pack.sv */
`timescale 1ns/1ns

module float_round_pack (
	input	logic		clk,
	input	logic		reset,
	input	logic		valid_in,
	output	logic		ready_out,
	input	fpu_pkg::man_t	man_y,
	input	fpu_pkg::exp_t	exp_y,
	input	logic		sgn_y,
	input	logic		round_bit,
	input	logic		sticky_bit,
	input	logic		skip_round,
	input	logic		iv,
	input	logic		dz,
	input	fpu_pkg::rm_t	rm,
	output	logic		out_valid,
	input	logic		out_ready,
	output	fpu_pkg::word_t	y,
	output	fpu_pkg::flags_t	flags
);
	import fpu_pkg::*;

	logic		inexact;
	logic		inc;
	logic [24:0]	man_r;
	exp_t		exp_r;
	exp_t		biased;
	logic		to_max;
	word_t		y_next;
	flags_t		flags_next;

	assign ready_out = !out_valid || out_ready;
	assign inexact = round_bit || sticky_bit;

	always_comb begin
		case (rm)
			RTZ: inc = 1'b0;
			RDN: inc = inexact && sgn_y;
			RUP: inc = inexact && !sgn_y;
			RMM: inc = round_bit;
			default: inc = round_bit && (sticky_bit || man_y[0]);	// ties to even.
		endcase
	end

	assign man_r = {1'b0, man_y} + 25'(inc);
	assign exp_r = exp_y + exp_t'(man_r[24]);	// carry out renormalizes.
	assign biased = exp_r + exp_t'(exp_bias);
	assign to_max = (rm == RTZ) || (rm == RDN && !sgn_y) || (rm == RUP && sgn_y);

	always_comb begin
		flags_next = '0;
		if (skip_round) begin
			y_next = {sgn_y, exp_y[7:0], man_y[22:0]};
			flags_next[flag_nv] = iv;
			flags_next[flag_dz] = dz;
		end else if ($signed(biased) >= 255) begin
			y_next = to_max ? {sgn_y, 8'hfe, 23'h7fffff} : {sgn_y, 8'hff, 23'h0};
			flags_next[flag_of] = 1'b1;
			flags_next[flag_nx] = 1'b1;
		end else if ($signed(biased) < 1) begin
			y_next = {sgn_y, 31'h0};	// flush to zero.
			flags_next[flag_uf] = 1'b1;
			flags_next[flag_nx] = 1'b1;
		end else begin
			y_next = {sgn_y, biased[7:0], man_r[22:0]};
			flags_next[flag_nx] = inexact;
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			out_valid <= 1'b0;
		else if (valid_in && ready_out)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (valid_in && ready_out) begin
			y <= y_next;
			flags <= flags_next;
		end
	end

endmodule

/* logic/fpu_csr.sv */
`timescale 1ns/1ns

module fpu_csr #(
	parameter int axi_addr_width = 4
) (
	input	logic				clk,
	input	logic				reset,
	input	logic [axi_addr_width-1:0]	awaddr,
	input	logic				awvalid,
	output	logic				awready,
	input	logic [31:0]			wdata,
	input	logic [3:0]			wstrb,
	input	logic				wvalid,
	output	logic				wready,
	output	logic [1:0]			bresp,
	output	logic				bvalid,
	input	logic				bready,
	input	logic [axi_addr_width-1:0]	araddr,
	input	logic				arvalid,
	output	logic				arready,
	output	logic [31:0]			rdata,
	output	logic [1:0]			rresp,
	output	logic				rvalid,
	input	logic				rready,
	input	fpu_pkg::flags_t		flags,
	input	logic				flags_valid,
	output	fpu_pkg::rm_t			frm
);
	import fpu_pkg::*;

	flags_t	fflags;
	flags_t	fflags_wr;
	logic	wr_en;
	logic	rd_en;

	assign bresp = 2'b00;
	assign rresp = 2'b00;
	assign wr_en = awready && awvalid && wvalid;
	assign rd_en = arready && arvalid;

	// software write lands first, hardware flags OR on top.
	assign fflags_wr = (wr_en && wstrb[0] && awaddr == csr_fflags_addr[axi_addr_width-1:0]) ?
		wdata[4:0] : fflags;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			frm <= RNE;
			fflags <= '0;
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready <= awvalid && wvalid && !awready && !bvalid;
			arready <= arvalid && !arready && !rvalid;
			if (wr_en)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_en)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (wr_en && wstrb[0] && awaddr == csr_frm_addr[axi_addr_width-1:0] &&
					wdata[2:0] <= 3'd4)
				frm <= rm_t'(wdata[2:0]);
			fflags <= fflags_wr | (flags_valid ? flags : flags_t'(0));
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			if (araddr == csr_frm_addr[axi_addr_width-1:0])
				rdata <= {29'd0, frm};
			else if (araddr == csr_fflags_addr[axi_addr_width-1:0])
				rdata <= {27'd0, fflags};
			else
				rdata <= 32'd0;
		end
	end

	bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid);

endmodule

/* logic/fdiv_unit.sv */
`timescale 1ns/1ns

module fdiv_unit #(
	parameter int axi_addr_width = 4,
	parameter int div_steps = 13
) (
	input	logic				clk,
	input	logic				reset,
	input	logic				in_valid,
	output	logic				in_ready,
	input	fpu_pkg::word_t			a,
	input	fpu_pkg::word_t			b,
	input	fpu_pkg::rm_t			rm,
	output	logic				out_valid,
	input	logic				out_ready,
	output	fpu_pkg::word_t			y,
	output	fpu_pkg::flags_t		flags,
	input	logic [axi_addr_width-1:0]	awaddr,
	input	logic				awvalid,
	output	logic				awready,
	input	logic [31:0]			wdata,
	input	logic [3:0]			wstrb,
	input	logic				wvalid,
	output	logic				wready,
	output	logic [1:0]			bresp,
	output	logic				bvalid,
	input	logic				bready,
	input	logic [axi_addr_width-1:0]	araddr,
	input	logic				arvalid,
	output	logic				arready,
	output	logic [31:0]			rdata,
	output	logic [1:0]			rresp,
	output	logic				rvalid,
	input	logic				rready
);
	import fpu_pkg::*;

	man_t	man_a, man_b, man_y;
	exp_t	exp_a, exp_b, exp_y;
	logic	sgn_a, sgn_b, zero_a, zero_b, inf_a, inf_b;
	logic	snan_a, snan_b, qnan_a, qnan_b;
	logic	sgn_y, round_bit, sticky_bit, skip_round, iv, dz;
	logic	div_valid, rp_ready;
	rm_t	frm, rm_sel, rm_div;

	float_unpack u_unpack (
		.a(a), .b(b), .rm(rm), .frm(frm),
		.man_a(man_a), .man_b(man_b), .exp_a(exp_a), .exp_b(exp_b),
		.sgn_a(sgn_a), .sgn_b(sgn_b), .zero_a(zero_a), .zero_b(zero_b),
		.inf_a(inf_a), .inf_b(inf_b), .snan_a(snan_a), .snan_b(snan_b),
		.qnan_a(qnan_a), .qnan_b(qnan_b), .rm_sel(rm_sel)
	);

	float_divider #(.div_steps(div_steps)) u_divider (
		.clk(clk), .reset(reset),
		.valid_in(in_valid), .ready_out(in_ready),
		.valid_out(div_valid), .ready_in(rp_ready), .rm(rm_sel),
		.man_a(man_a), .exp_a(exp_a), .sgn_a(sgn_a), .zero_a(zero_a),
		.inf_a(inf_a), .snan_a(snan_a), .qnan_a(qnan_a),
		.man_b(man_b), .exp_b(exp_b), .sgn_b(sgn_b), .zero_b(zero_b),
		.inf_b(inf_b), .snan_b(snan_b), .qnan_b(qnan_b),
		.man_y(man_y), .exp_y(exp_y), .sgn_y(sgn_y),
		.round_bit(round_bit), .sticky_bit(sticky_bit), .skip_round(skip_round),
		.iv(iv), .dz(dz), .rm_out(rm_div)
	);

	float_round_pack u_round_pack (
		.clk(clk), .reset(reset),
		.valid_in(div_valid), .ready_out(rp_ready),
		.man_y(man_y), .exp_y(exp_y), .sgn_y(sgn_y),
		.round_bit(round_bit), .sticky_bit(sticky_bit), .skip_round(skip_round),
		.iv(iv), .dz(dz), .rm(rm_div),
		.out_valid(out_valid), .out_ready(out_ready), .y(y), .flags(flags)
	);

	fpu_csr #(.axi_addr_width(axi_addr_width)) u_csr (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.flags(flags), .flags_valid(out_valid && out_ready),	// flags accrue per transfer.
		.frm(frm)
	);

endmodule

/* bench/fdiv_unit_tb.sv */
`timescale 1ns/1ns

module fdiv_unit_tb;
	import fpu_pkg::*;

	logic		clk;
	logic		reset;
	logic		in_valid;
	logic		in_ready;
	word_t		a;
	word_t		b;
	rm_t		rm;
	logic		out_valid;
	logic		out_ready;
	word_t		y;
	flags_t		flags;
	logic [3:0]	awaddr;
	logic		awvalid;
	logic		awready;
	logic [31:0]	wdata;
	logic [3:0]	wstrb;
	logic		wvalid;
	logic		wready;
	logic [1:0]	bresp;
	logic		bvalid;
	logic		bready;
	logic [3:0]	araddr;
	logic		arvalid;
	logic		arready;
	logic [31:0]	rdata;
	logic [1:0]	rresp;
	logic		rvalid;
	logic		rready;

	integer		seed = 32'h9800;
	integer		cycles;
	integer		cycle_limit;
	integer		i;
	integer		mon_tag;

	// one entry per test line, five hex columns.
	logic [7:0]	kind_q[$];
	logic [31:0]	col1_q[$];
	logic [31:0]	col2_q[$];
	logic [31:0]	col3_q[$];
	logic [31:0]	col4_q[$];
	logic [31:0]	col5_q[$];

	// scoreboard, in acceptance order.
	logic [31:0]	exp_y_q[$];
	logic [31:0]	exp_flags_q[$];
	integer		exp_tag_q[$];

	fdiv_unit u_dut (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .a(a), .b(b), .rm(rm),
		.out_valid(out_valid), .out_ready(out_ready), .y(y), .flags(flags),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	always #20 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic read_tests;
		integer fd;
		integer n;
		logic [7:0] kind;
		logic [31:0] f1, f2, f3, f4, f5;
		logic [8*160-1:0] rest;
		fd = $fopen("bench/fdiv_tests.txt", "r");
		if (fd == 0)
			abort_run("cannot open bench/fdiv_tests.txt");
		else begin
			n = $fscanf(fd, " %c", kind);
			while (n == 1) begin
				f1 = 0;
				f2 = 0;
				f3 = 0;
				f4 = 0;
				f5 = 0;
				if (kind == "#")
					n = $fgets(rest, fd);	// comment line.
				else if (kind == "W" || kind == "R") begin
					if ($fscanf(fd, "%h %h", f1, f2) != 2)
						abort_run("malformed register line in test file");
				end else if (kind == "D") begin
					if ($fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5) != 5)
						abort_run("malformed division line in test file");
				end else
					abort_run("unknown line type in test file");
				if (kind != "#") begin
					kind_q.push_back(kind);
					col1_q.push_back(f1);
					col2_q.push_back(f2);
					col3_q.push_back(f3);
					col4_q.push_back(f4);
					col5_q.push_back(f5);
				end
				n = $fscanf(fd, " %c", kind);
			end
			$fclose(fd);
		end
	endtask

	task automatic issue(input integer idx);
		a <= col1_q[idx];
		b <= col2_q[idx];
		rm <= rm_t'(col3_q[idx][2:0]);
		in_valid <= 1'b1;
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		exp_y_q.push_back(col4_q[idx]);
		exp_flags_q.push_back(col5_q[idx]);
		exp_tag_q.push_back(idx);
	endtask

	// stop issuing and wait for the scoreboard to empty.
	task automatic drain;
		in_valid <= 1'b0;
		while (exp_y_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input integer idx);
		awaddr <= addr;
		wdata <= data;
		wstrb <= 4'hf;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		@(posedge clk);
		while (!(awready && wready))
			@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(posedge clk);
		while (!bvalid)
			@(posedge clk);
		check(bresp, 2'b00, $sformatf("entry %0d write response", idx));
		bready <= 1'b1;	// response waits one cycle first.
		@(posedge clk);
		check(bvalid, 1'b1, $sformatf("entry %0d write response held", idx));
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, input logic [31:0] expected,
			input integer idx);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b1;
		@(posedge clk);
		while (!arready)
			@(posedge clk);
		arvalid <= 1'b0;
		@(posedge clk);
		while (!rvalid)
			@(posedge clk);
		check(rresp, 2'b00, $sformatf("entry %0d read response", idx));
		check(rdata, expected, $sformatf("entry %0d read data", idx));
		rready <= 1'b0;
	endtask

	always @(posedge clk) begin
		if (!reset)
			out_ready <= ($random(seed) & 3) != 0;	// ready about 3 cycles in 4.
	end

	always @(posedge clk) begin
		if (!reset && out_valid && out_ready) begin
			if (exp_y_q.size() == 0)
				abort_run("a result came out with no division outstanding");
			else begin
				mon_tag = exp_tag_q.pop_front();
				check(y, exp_y_q.pop_front(), $sformatf("entry %0d result", mon_tag));
				check({27'd0, flags}, exp_flags_q.pop_front(),
					$sformatf("entry %0d flags", mon_tag));
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
			abort_run("timeout, the DUT stopped responding");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		rm = RNE;
		out_ready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		cycles = 0;
		cycle_limit = 1000;
		read_tests();
		cycle_limit = 40 * kind_q.size() + 1000;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (i = 0; i < kind_q.size(); i++) begin
			if (kind_q[i] == "D")
				issue(i);	// back to back while results are still held.
			else begin
				drain();
				if (kind_q[i] == "W")
					axi_write(col1_q[i][3:0], col2_q[i], i);
				else
					axi_read(col1_q[i][3:0], col2_q[i], i);
			end
		end
		drain();
		repeat (20) @(posedge clk);	// a stray or repeated result shows up here.
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* fdiv_unit.f */
logic/fpu_pkg.sv
logic/float_unpack.sv
logic/float_divider.sv
logic/float_round_pack.sv
logic/fpu_csr.sv
logic/fdiv_unit.sv
bench/fdiv_unit_tb.sv

/* bench/fdiv_tests.txt */
# columns: W addr data | R addr expect_data | D a b rm expect_y expect_flags, all hex
# flags: nv dz of uf nx from bit 4 down; rm: 0 rne, 1 rtz, 2 rdn, 3 rup, 4 rmm, 7 dyn
R 0 0
R 4 0
D 40c00000 40400000 0 40000000 00
D 3f800000 40800000 0 3e800000 00
D c1100000 3f000000 0 c1900000 00
R 4 0
D 3f800000 40400000 0 3eaaaaab 01
D 3f800000 40400000 1 3eaaaaaa 01
D 3f800000 40400000 2 3eaaaaaa 01
D 3f800000 40400000 3 3eaaaaab 01
D 3f800000 40400000 4 3eaaaaab 01
D bf800000 40400000 2 beaaaaab 01
D bf800000 40400000 3 beaaaaaa 01
D 40000000 40400000 0 3f2aaaab 01
D 40000000 40400000 1 3f2aaaaa 01
R 4 1
W 4 0
R 4 0
D 00000000 00000000 0 7fc00000 10
D 7f800000 ff800000 0 7fc00000 10
D 7f800001 3f800000 0 7fc00000 10
D 3f800000 ff800001 0 7fc00000 10
D 3f800000 00000000 0 7f800000 08
D bf800000 00000000 0 ff800000 08
D 40400000 80000000 0 ff800000 08
D 00000000 40400000 0 00000000 00
D 80000000 40400000 0 80000000 00
D 40400000 ff800000 0 80000000 00
D 7fc00000 3f800000 0 7fc00000 00
D 3f800000 ffc12345 0 7fc00000 00
R 4 18
D 7f7fffff 00800000 0 7f800000 05
D 7f7fffff 00800000 1 7f7fffff 05
D ff7fffff 00800000 2 ff800000 05
D ff7fffff 00800000 3 ff7fffff 05
D 00800000 7f7fffff 0 00000000 03
D 80800000 7f7fffff 0 80000000 03
R 4 1f
W 4 0
W 0 1
R 0 1
D 3f800000 40400000 7 3eaaaaaa 01
W 0 7
R 0 1
W 0 3
D 40000000 40400000 7 3f2aaaab 01
R 4 1
W 8 5
R 8 0
W 4 0
R 4 0
